// ==== verilog/mpmc_cfg_pkg.sv ====
`default_nettype none

package mpmc_cfg_pkg;

	// ========================================
	// Channels
	// ========================================

	// Number of client channels that share the line store
	localparam int NUM_CH = 4;

	// Width of a channel number, used for the round-robin pointer
	localparam int CH_IDX_W = $clog2(NUM_CH);

	// ========================================
	// Line geometry
	// ========================================

	// One byte lane, the unit of the write strobes
	localparam int BYTE_W = 8;

	// Every access moves a full line between the port and the store
	localparam int LINE_W = 128;
	localparam int LINE_BYTES = LINE_W / BYTE_W;

	// ========================================
	// Address map
	// ========================================

	// Byte address of the 4 KiB space
	localparam int ADDR_W = 12;

	// Low bits pick the byte inside a line, the rest pick the line
	localparam int OFS_W = $clog2(LINE_BYTES);
	localparam int IDX_W = ADDR_W - OFS_W;

	// Lines in the store, 256 for the whole space
	localparam int DEPTH = 1 << IDX_W;

endpackage

`default_nettype wire

// ==== verilog/mpmc_line_pkg.sv ====
`default_nettype none

package mpmc_line_pkg;

	// ========================================
	// Line store types
	// ========================================

	// One line as it sits in the store
	typedef logic [mpmc_cfg_pkg::LINE_W-1:0] line_t;

	// One strobe bit per byte lane of a line
	typedef logic [mpmc_cfg_pkg::LINE_BYTES-1:0] strb_t;

	// Line number inside the store
	typedef logic [mpmc_cfg_pkg::IDX_W-1:0] line_idx_t;

	// One bit per channel, either one-hot or a set of requests
	typedef logic [mpmc_cfg_pkg::NUM_CH-1:0] ch_mask_t;

	// ========================================
	// Channel data words
	// ========================================

	// Channel 0 moves a full line, the others a narrower field of it
	typedef logic [127:0] ch0_data_t;
	typedef logic [63:0] ch1_data_t;
	typedef logic [31:0] ch2_data_t;
	typedef logic [7:0] ch3_data_t;

endpackage

`default_nettype wire

// ==== verilog/mpmc_apb_port.sv ====
`default_nettype none

module mpmc_apb_port #(
	parameter type data_t = mpmc_line_pkg::ch0_data_t
) (
	input logic clk0,
	input logic reset,
	// APB slave side
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [mpmc_cfg_pkg::ADDR_W-1:0] paddr,
	input data_t pwdata,
	input logic [$bits(data_t)/mpmc_cfg_pkg::BYTE_W-1:0] pstrb,
	output data_t prdata,
	output logic pready,
	// Request toward the arbiter
	output logic req,
	output logic we,
	output mpmc_line_pkg::line_idx_t line_idx,
	output mpmc_line_pkg::line_t wline,
	output mpmc_line_pkg::strb_t wstrb,
	input logic gnt,
	// Read data coming back from the steering block
	input logic rd_valid,
	input data_t rd_data
);

	// Channel word size in bits and bytes, and how often it fits in a line
	localparam int dw = $bits(data_t);
	localparam int db = dw / mpmc_cfg_pkg::BYTE_W;
	localparam int rep = mpmc_cfg_pkg::LINE_W / dw;

	typedef enum logic [1:0] {
		st_idle,
		st_wgnt,
		st_wdata
	} state_t;

	state_t state;
	logic accept;
	int lane_byte;

	// Request held while the arbiter and the store work on it
	logic we_q;
	mpmc_line_pkg::line_idx_t idx_q;
	mpmc_line_pkg::line_t wline_q;
	mpmc_line_pkg::strb_t wstrb_q;

	// A new transfer is taken only in the first access cycle
	assign accept = (state == st_idle) && psel && penable;

	// The address aligned down to the word picks the first byte lane of the channel word
	always_comb begin
		lane_byte = (int'(paddr[mpmc_cfg_pkg::OFS_W-1:0]) / db) * db;
	end

	// ========================================
	// Request capture
	// ========================================

	always_ff @(posedge clk0) begin
		if (accept) begin
			we_q <= pwrite;
			idx_q <= paddr[mpmc_cfg_pkg::ADDR_W-1:mpmc_cfg_pkg::OFS_W];
			// The word goes to every lane and the strobes pick the one that counts
			wline_q <= {rep{pwdata}};
			// Reads keep all strobes low
			if (pwrite) begin
				wstrb_q <= mpmc_line_pkg::strb_t'(pstrb) << lane_byte;
			end else begin
				wstrb_q <= '0;
			end
		end
	end

	// ========================================
	// Transfer FSM
	// ========================================

	always_ff @(posedge clk0) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_wgnt;
					end
				end
				st_wgnt: begin
					// A write is finished once the store has taken it
					if (gnt) begin
						state <= we_q ? st_idle : st_wdata;
					end
				end
				st_wdata: begin
					if (rd_valid) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign req = (state == st_wgnt);
	assign we = we_q;
	assign line_idx = idx_q;
	assign wline = wline_q;
	assign wstrb = wstrb_q;

	// Writes end on the grant and reads when the steered word shows up
	assign pready = ((state == st_wgnt) && gnt && we_q) || ((state == st_wdata) && rd_valid);

	// Read data comes straight from the steering block, which holds zero between reads
	assign prdata = rd_data;

endmodule

`default_nettype wire

// ==== verilog/mpmc_arbiter.sv ====
`default_nettype none

module mpmc_arbiter (
	input logic clk0,
	input logic reset,
	input mpmc_line_pkg::ch_mask_t req,
	input logic [mpmc_cfg_pkg::NUM_CH-1:0] we,
	input mpmc_line_pkg::line_idx_t line_idx [mpmc_cfg_pkg::NUM_CH],
	input mpmc_line_pkg::line_t wline [mpmc_cfg_pkg::NUM_CH],
	input mpmc_line_pkg::strb_t wstrb [mpmc_cfg_pkg::NUM_CH],
	output mpmc_line_pkg::ch_mask_t gnt,
	// Granted request toward the line store
	output logic mem_en,
	output logic mem_we,
	output mpmc_line_pkg::line_idx_t mem_idx,
	output mpmc_line_pkg::line_t mem_wline,
	output mpmc_line_pkg::strb_t mem_wstrb,
	output mpmc_line_pkg::ch_mask_t mem_sel
);

	logic [mpmc_cfg_pkg::CH_IDX_W-1:0] last_q;
	logic [mpmc_cfg_pkg::CH_IDX_W-1:0] win;
	logic found;
	mpmc_line_pkg::ch_mask_t elig;

	// The port still shows req in the cycle its grant comes back, so mask it
	assign elig = req & ~gnt;

	// Search starts just after the last winner, which ends up last in line
	always_comb begin
		int j;
		win = last_q;
		found = 1'b0;
		for (int i = 1; i <= mpmc_cfg_pkg::NUM_CH; i++) begin
			j = (int'(last_q) + i) % mpmc_cfg_pkg::NUM_CH;
			if (!found && elig[j]) begin
				win = j[mpmc_cfg_pkg::CH_IDX_W-1:0];
				found = 1'b1;
			end
		end
	end

	always_comb begin
		mem_sel = '0;
		if (found) begin
			mem_sel[win] = 1'b1;
		end
	end

	// Winner's fields go straight to the store in the same cycle
	assign mem_en = found;
	assign mem_we = we[win];
	assign mem_idx = line_idx[win];
	assign mem_wline = wline[win];
	assign mem_wstrb = wstrb[win];

	always_ff @(posedge clk0) begin
		if (reset) begin
			gnt <= '0;
			last_q <= '0;
		end else begin
			gnt <= mem_sel;
			if (found) begin
				last_q <= win;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mpmc_line_ram.sv ====
`default_nettype none

module mpmc_line_ram (
	input logic clk0,
	input logic reset,
	input logic en,
	input logic we,
	input mpmc_line_pkg::line_idx_t idx,
	input mpmc_line_pkg::line_t wline,
	input mpmc_line_pkg::strb_t wstrb,
	input mpmc_line_pkg::ch_mask_t sel,
	output mpmc_line_pkg::line_t rd_line,
	output mpmc_line_pkg::ch_mask_t rd_sel
);

	localparam int bw = mpmc_cfg_pkg::BYTE_W;

	mpmc_line_pkg::line_t mem [mpmc_cfg_pkg::DEPTH];

	// ========================================
	// Storage array
	// ========================================

	always_ff @(posedge clk0) begin
		if (en && we) begin
			// Only strobed lanes change, the rest of the line is kept
			for (int b = 0; b < mpmc_cfg_pkg::LINE_BYTES; b++) begin
				if (wstrb[b]) begin
					mem[idx][b*bw +: bw] <= wline[b*bw +: bw];
				end
			end
		end
		// The read port holds its last line between reads
		if (en && !we) begin
			rd_line <= mem[idx];
		end
	end

	// Owner tag travels with the read line, one cycle after the grant
	always_ff @(posedge clk0) begin
		if (reset) begin
			rd_sel <= '0;
		end else if (en && !we) begin
			rd_sel <= sel;
		end else begin
			rd_sel <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mpmc_data_output.sv ====
`default_nettype none

module mpmc_data_output #(
	parameter type data_t = mpmc_line_pkg::ch0_data_t
) (
	input logic clk0,
	input logic reset,
	input logic sel,
	input logic [mpmc_cfg_pkg::OFS_W-1:0] adr,
	input mpmc_line_pkg::line_t line,
	output data_t dato,
	output logic valid
);

	// Channel word size, in bits and in bytes
	localparam int dw = $bits(data_t);
	localparam int db = dw / mpmc_cfg_pkg::BYTE_W;

	int shift;

	// Bit offset of the addressed word, address aligned down to the word size
	// A full-width channel always gets zero here
	always_comb begin
		shift = (int'(adr) / db) * db * mpmc_cfg_pkg::BYTE_W;
	end

	// ========================================
	// Output register
	// ========================================

	// Unselected outputs sit at zero so that several of them could be OR-ed
	always_ff @(posedge clk0) begin
		if (reset) begin
			dato <= '0;
			valid <= 1'b0;
		end else begin
			valid <= sel;
			if (sel) begin
				// The cast keeps the low dw bits after the shift
				dato <= data_t'(line >> shift);
			end else begin
				dato <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mpmc_top.sv ====
`default_nettype none

module mpmc_top (
	input logic clk0,
	input logic reset,
	// Channel 0, full line
	input logic psel0,
	input logic penable0,
	input logic pwrite0,
	input logic [mpmc_cfg_pkg::ADDR_W-1:0] paddr0,
	input mpmc_line_pkg::ch0_data_t pwdata0,
	input logic [15:0] pstrb0,
	output mpmc_line_pkg::ch0_data_t prdata0,
	output logic pready0,
	// Channel 1, 64 bits
	input logic psel1,
	input logic penable1,
	input logic pwrite1,
	input logic [mpmc_cfg_pkg::ADDR_W-1:0] paddr1,
	input mpmc_line_pkg::ch1_data_t pwdata1,
	input logic [7:0] pstrb1,
	output mpmc_line_pkg::ch1_data_t prdata1,
	output logic pready1,
	// Channel 2, 32 bits
	input logic psel2,
	input logic penable2,
	input logic pwrite2,
	input logic [mpmc_cfg_pkg::ADDR_W-1:0] paddr2,
	input mpmc_line_pkg::ch2_data_t pwdata2,
	input logic [3:0] pstrb2,
	output mpmc_line_pkg::ch2_data_t prdata2,
	output logic pready2,
	// Channel 3, one byte
	input logic psel3,
	input logic penable3,
	input logic pwrite3,
	input logic [mpmc_cfg_pkg::ADDR_W-1:0] paddr3,
	input mpmc_line_pkg::ch3_data_t pwdata3,
	input logic [0:0] pstrb3,
	output mpmc_line_pkg::ch3_data_t prdata3,
	output logic pready3
);

	// ========================================
	// Port to arbiter requests
	// ========================================

	mpmc_line_pkg::ch_mask_t ch_req;
	mpmc_line_pkg::ch_mask_t ch_gnt;
	logic [mpmc_cfg_pkg::NUM_CH-1:0] ch_we;
	mpmc_line_pkg::line_idx_t ch_idx [mpmc_cfg_pkg::NUM_CH];
	mpmc_line_pkg::line_t ch_wline [mpmc_cfg_pkg::NUM_CH];
	mpmc_line_pkg::strb_t ch_wstrb [mpmc_cfg_pkg::NUM_CH];

	// Granted request into the store, and the tagged read line out of it
	logic mem_en;
	logic mem_we;
	mpmc_line_pkg::line_idx_t mem_idx;
	mpmc_line_pkg::line_t mem_wline;
	mpmc_line_pkg::strb_t mem_wstrb;
	mpmc_line_pkg::ch_mask_t mem_sel;
	mpmc_line_pkg::line_t rd_line;
	mpmc_line_pkg::ch_mask_t rd_sel;

	// Steered read words, one per channel
	logic ch0_rd_valid;
	logic ch1_rd_valid;
	logic ch2_rd_valid;
	logic ch3_rd_valid;
	mpmc_line_pkg::ch0_data_t ch0_rd_data;
	mpmc_line_pkg::ch1_data_t ch1_rd_data;
	mpmc_line_pkg::ch2_data_t ch2_rd_data;
	mpmc_line_pkg::ch3_data_t ch3_rd_data;

	// ========================================
	// Channel ports
	// ========================================

	mpmc_apb_port #(.data_t(mpmc_line_pkg::ch0_data_t)) port0 (
		.clk0(clk0), .reset(reset),
		.psel(psel0), .penable(penable0), .pwrite(pwrite0), .paddr(paddr0),
		.pwdata(pwdata0), .pstrb(pstrb0), .prdata(prdata0), .pready(pready0),
		.req(ch_req[0]), .we(ch_we[0]), .line_idx(ch_idx[0]),
		.wline(ch_wline[0]), .wstrb(ch_wstrb[0]), .gnt(ch_gnt[0]),
		.rd_valid(ch0_rd_valid), .rd_data(ch0_rd_data)
	);

	mpmc_apb_port #(.data_t(mpmc_line_pkg::ch1_data_t)) port1 (
		.clk0(clk0), .reset(reset),
		.psel(psel1), .penable(penable1), .pwrite(pwrite1), .paddr(paddr1),
		.pwdata(pwdata1), .pstrb(pstrb1), .prdata(prdata1), .pready(pready1),
		.req(ch_req[1]), .we(ch_we[1]), .line_idx(ch_idx[1]),
		.wline(ch_wline[1]), .wstrb(ch_wstrb[1]), .gnt(ch_gnt[1]),
		.rd_valid(ch1_rd_valid), .rd_data(ch1_rd_data)
	);

	mpmc_apb_port #(.data_t(mpmc_line_pkg::ch2_data_t)) port2 (
		.clk0(clk0), .reset(reset),
		.psel(psel2), .penable(penable2), .pwrite(pwrite2), .paddr(paddr2),
		.pwdata(pwdata2), .pstrb(pstrb2), .prdata(prdata2), .pready(pready2),
		.req(ch_req[2]), .we(ch_we[2]), .line_idx(ch_idx[2]),
		.wline(ch_wline[2]), .wstrb(ch_wstrb[2]), .gnt(ch_gnt[2]),
		.rd_valid(ch2_rd_valid), .rd_data(ch2_rd_data)
	);

	mpmc_apb_port #(.data_t(mpmc_line_pkg::ch3_data_t)) port3 (
		.clk0(clk0), .reset(reset),
		.psel(psel3), .penable(penable3), .pwrite(pwrite3), .paddr(paddr3),
		.pwdata(pwdata3), .pstrb(pstrb3), .prdata(prdata3), .pready(pready3),
		.req(ch_req[3]), .we(ch_we[3]), .line_idx(ch_idx[3]),
		.wline(ch_wline[3]), .wstrb(ch_wstrb[3]), .gnt(ch_gnt[3]),
		.rd_valid(ch3_rd_valid), .rd_data(ch3_rd_data)
	);

	// ========================================
	// Arbiter and line store
	// ========================================

	mpmc_arbiter arb0 (
		.clk0(clk0), .reset(reset),
		.req(ch_req), .we(ch_we), .line_idx(ch_idx), .wline(ch_wline), .wstrb(ch_wstrb),
		.gnt(ch_gnt),
		.mem_en(mem_en), .mem_we(mem_we), .mem_idx(mem_idx),
		.mem_wline(mem_wline), .mem_wstrb(mem_wstrb), .mem_sel(mem_sel)
	);

	mpmc_line_ram ram0 (
		.clk0(clk0), .reset(reset),
		.en(mem_en), .we(mem_we), .idx(mem_idx),
		.wline(mem_wline), .wstrb(mem_wstrb), .sel(mem_sel),
		.rd_line(rd_line), .rd_sel(rd_sel)
	);

	// ========================================
	// Read steering
	// ========================================

	// The master holds paddr until pready, so the low bits are still valid here
	mpmc_data_output #(.data_t(mpmc_line_pkg::ch0_data_t)) dout0 (
		.clk0(clk0), .reset(reset), .sel(rd_sel[0]),
		.adr(paddr0[mpmc_cfg_pkg::OFS_W-1:0]), .line(rd_line),
		.dato(ch0_rd_data), .valid(ch0_rd_valid)
	);

	mpmc_data_output #(.data_t(mpmc_line_pkg::ch1_data_t)) dout1 (
		.clk0(clk0), .reset(reset), .sel(rd_sel[1]),
		.adr(paddr1[mpmc_cfg_pkg::OFS_W-1:0]), .line(rd_line),
		.dato(ch1_rd_data), .valid(ch1_rd_valid)
	);

	mpmc_data_output #(.data_t(mpmc_line_pkg::ch2_data_t)) dout2 (
		.clk0(clk0), .reset(reset), .sel(rd_sel[2]),
		.adr(paddr2[mpmc_cfg_pkg::OFS_W-1:0]), .line(rd_line),
		.dato(ch2_rd_data), .valid(ch2_rd_valid)
	);

	mpmc_data_output #(.data_t(mpmc_line_pkg::ch3_data_t)) dout3 (
		.clk0(clk0), .reset(reset), .sel(rd_sel[3]),
		.adr(paddr3[mpmc_cfg_pkg::OFS_W-1:0]), .line(rd_line),
		.dato(ch3_rd_data), .valid(ch3_rd_valid)
	);

endmodule

`default_nettype wire

// ==== verif/mpmc_props.sv ====
`default_nettype none

module mpmc_props (
	input logic clk0,
	input logic reset,
	input mpmc_line_pkg::ch_mask_t gnt,
	input mpmc_line_pkg::ch_mask_t req,
	// APB handshake of all four channels, bit k for channel k
	input mpmc_line_pkg::ch_mask_t psel,
	input mpmc_line_pkg::ch_mask_t penable,
	input mpmc_line_pkg::ch_mask_t pready,
	input mpmc_line_pkg::ch_mask_t prdata_nz
);

	// Longest time a request may stay up before its grant takes it away
	localparam int req_limit = 16;

	// Cycles each channel's request has been up without a break
	int req_age [mpmc_cfg_pkg::NUM_CH];

	always_ff @(posedge clk0) begin
		for (int i = 0; i < mpmc_cfg_pkg::NUM_CH; i++) begin
			if (reset || !req[i]) begin
				req_age[i] <= 0;
			end else begin
				req_age[i] <= req_age[i] + 1;
			end
		end
	end

	// ========================================
	// Protocol checks
	// ========================================

	// At most one channel reaches the line store per cycle
	assert property (@(posedge clk0) disable iff (reset) $onehot0(gnt))
		else $error("grant vector has more than one bit set");

	// A transfer can only end inside an access phase
	assert property (@(posedge clk0) disable iff (reset) (pready & ~(psel & penable)) == '0)
		else $error("pready high outside an APB access phase");

	assert property (@(posedge clk0) disable iff (reset) (prdata_nz & ~pready) == '0)
		else $error("prdata not zero while pready is low");

	for (genvar i = 0; i < mpmc_cfg_pkg::NUM_CH; i++) begin : g_req
		assert property (@(posedge clk0) disable iff (reset) req_age[i] < req_limit)
			else $error("request of channel %0d waited too long for a grant", i);
	end

endmodule

bind mpmc_top mpmc_props props0 (
	.clk0(clk0),
	.reset(reset),
	.gnt(ch_gnt),
	.req(ch_req),
	.psel({psel3, psel2, psel1, psel0}),
	.penable({penable3, penable2, penable1, penable0}),
	.pready({pready3, pready2, pready1, pready0}),
	.prdata_nz({|prdata3, |prdata2, |prdata1, |prdata0})
);

`default_nettype wire

// ==== verif/mpmc_tb.sv ====
`default_nettype none

module mpmc_tb;

	// Cycles a master waits for pready before it gives up on a transfer
	localparam int wait_limit = 64;

	// Each channel keeps to its own quarter of the store under contention
	localparam int region_lines = mpmc_cfg_pkg::DEPTH / mpmc_cfg_pkg::NUM_CH;

	logic clk0 = 1'b0;
	logic reset = 1'b1;

	// ========================================
	// APB signals, one set per channel
	// ========================================

	logic psel0 = 1'b0;
	logic penable0 = 1'b0;
	logic pwrite0 = 1'b0;
	logic [11:0] paddr0 = '0;
	mpmc_line_pkg::ch0_data_t pwdata0 = '0;
	logic [15:0] pstrb0 = '0;
	mpmc_line_pkg::ch0_data_t prdata0;
	logic pready0;

	logic psel1 = 1'b0;
	logic penable1 = 1'b0;
	logic pwrite1 = 1'b0;
	logic [11:0] paddr1 = '0;
	mpmc_line_pkg::ch1_data_t pwdata1 = '0;
	logic [7:0] pstrb1 = '0;
	mpmc_line_pkg::ch1_data_t prdata1;
	logic pready1;

	logic psel2 = 1'b0;
	logic penable2 = 1'b0;
	logic pwrite2 = 1'b0;
	logic [11:0] paddr2 = '0;
	mpmc_line_pkg::ch2_data_t pwdata2 = '0;
	logic [3:0] pstrb2 = '0;
	mpmc_line_pkg::ch2_data_t prdata2;
	logic pready2;

	logic psel3 = 1'b0;
	logic penable3 = 1'b0;
	logic pwrite3 = 1'b0;
	logic [11:0] paddr3 = '0;
	mpmc_line_pkg::ch3_data_t pwdata3 = '0;
	logic [0:0] pstrb3 = '0;
	mpmc_line_pkg::ch3_data_t prdata3;
	logic pready3;

	logic [3:0] rdy;

	// Byte image of the whole 4 KiB space, updated as writes complete
	logic [7:0] model [1 << mpmc_cfg_pkg::ADDR_W];
	int err_cnt = 0;
	int tmo_cnt = 0;

	assign rdy = {pready3, pready2, pready1, pready0};

	always #50 clk0 = ~clk0;

	mpmc_top dut0 (.*);

	// ========================================
	// Helpers
	// ========================================

	// Channel word size in bytes: 128, 64, 32 and 8 bits
	function automatic int ch_bytes(input int ch);
		case (ch)
			0: return 16;
			1: return 8;
			2: return 4;
			default: return 1;
		endcase
	endfunction

	// Background pattern, every address bit has a say in the byte
	function automatic logic [7:0] fill_byte(input logic [11:0] a);
		return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'ha5;
	endfunction

	// Random address inside a range of lines, aligned down to the channel word
	function automatic logic [11:0] rand_addr(input int ch, input int first, input int count);
		int nb;
		int line_no;
		int ofs;
		nb = ch_bytes(ch);
		line_no = first + int'($urandom % count);
		ofs = (int'($urandom % 16) / nb) * nb;
		return 12'(line_no * 16 + ofs);
	endfunction

	task automatic compare_value(input string name, input logic [127:0] exp,
			input logic [127:0] got);
		assert (got === exp) else begin
			err_cnt++;
			$display("Error %s: expected %h, actual %h", name, exp, got);
		end
	endtask

	// Polls pready on the falling edge, where it is settled
	task automatic wait_ready(input int ch, input string name, output logic ok);
		int n;
		n = 0;
		while (!rdy[ch] && n < wait_limit) begin
			@(negedge clk0);
			n++;
		end
		ok = rdy[ch];
		if (!ok) begin
			tmo_cnt++;
			$display("Timeout in %s: channel %0d saw no pready in %0d cycles", name, ch, n);
		end
	endtask

	// ========================================
	// APB drivers, entered and left on a falling edge
	// ========================================

	task automatic apb_ch0(input string name, input logic wr, input logic [11:0] addr,
			input logic [127:0] wdata, input logic [15:0] strb,
			output logic [127:0] rdata, output logic ok);
		psel0 = 1'b1;
		penable0 = 1'b0;
		pwrite0 = wr;
		paddr0 = addr;
		pwdata0 = wdata;
		pstrb0 = strb;
		@(negedge clk0);
		penable0 = 1'b1;
		wait_ready(0, name, ok);
		rdata = prdata0;
		@(negedge clk0);
		psel0 = 1'b0;
		penable0 = 1'b0;
	endtask

	task automatic apb_ch1(input string name, input logic wr, input logic [11:0] addr,
			input logic [127:0] wdata, input logic [15:0] strb,
			output logic [127:0] rdata, output logic ok);
		psel1 = 1'b1;
		penable1 = 1'b0;
		pwrite1 = wr;
		paddr1 = addr;
		pwdata1 = wdata[63:0];
		pstrb1 = strb[7:0];
		@(negedge clk0);
		penable1 = 1'b1;
		wait_ready(1, name, ok);
		rdata = {64'h0, prdata1};
		@(negedge clk0);
		psel1 = 1'b0;
		penable1 = 1'b0;
	endtask

	task automatic apb_ch2(input string name, input logic wr, input logic [11:0] addr,
			input logic [127:0] wdata, input logic [15:0] strb,
			output logic [127:0] rdata, output logic ok);
		psel2 = 1'b1;
		penable2 = 1'b0;
		pwrite2 = wr;
		paddr2 = addr;
		pwdata2 = wdata[31:0];
		pstrb2 = strb[3:0];
		@(negedge clk0);
		penable2 = 1'b1;
		wait_ready(2, name, ok);
		rdata = {96'h0, prdata2};
		@(negedge clk0);
		psel2 = 1'b0;
		penable2 = 1'b0;
	endtask

	task automatic apb_ch3(input string name, input logic wr, input logic [11:0] addr,
			input logic [127:0] wdata, input logic [15:0] strb,
			output logic [127:0] rdata, output logic ok);
		psel3 = 1'b1;
		penable3 = 1'b0;
		pwrite3 = wr;
		paddr3 = addr;
		pwdata3 = wdata[7:0];
		pstrb3 = strb[0:0];
		@(negedge clk0);
		penable3 = 1'b1;
		wait_ready(3, name, ok);
		rdata = {120'h0, prdata3};
		@(negedge clk0);
		psel3 = 1'b0;
		penable3 = 1'b0;
	endtask

	// One transfer on a channel, then the model takes the write or checks the read
	task automatic run_xfer(input int ch, input string name, input logic wr,
			input logic [11:0] addr, input logic [127:0] wdata, input logic [15:0] strb);
		logic ok;
		logic [127:0] rdata;
		logic [127:0] exp;
		int nb;
		int base;
		case (ch)
			0: apb_ch0(name, wr, addr, wdata, strb, rdata, ok);
			1: apb_ch1(name, wr, addr, wdata, strb, rdata, ok);
			2: apb_ch2(name, wr, addr, wdata, strb, rdata, ok);
			default: apb_ch3(name, wr, addr, wdata, strb, rdata, ok);
		endcase
		if (ok) begin
			// The word covers the address aligned down to the channel width
			nb = ch_bytes(ch);
			base = (int'(addr) / nb) * nb;
			exp = '0;
			for (int b = 0; b < nb; b++) begin
				if (wr && strb[b]) begin
					model[base + b] = wdata[b*8 +: 8];
				end
				exp[b*8 +: 8] = model[base + b];
			end
			if (!wr) begin
				compare_value(name, exp, rdata);
			end
		end
	endtask

	// Random mix of reads and writes inside the channel's own region
	task automatic mix_traffic(input int ch);
		logic [11:0] addr;
		logic [127:0] data;
		logic wr;
		for (int i = 0; i < 50; i++) begin
			addr = rand_addr(ch, ch * region_lines, region_lines);
			data = {$urandom, $urandom, $urandom, $urandom};
			wr = 1'($urandom % 2);
			run_xfer(ch, "contention", wr, addr, data, 16'($urandom));
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [127:0] data;
		logic [11:0] addr;
		int line_no;
		void'($urandom(32'h2c50_5cd4));
		repeat (10) @(posedge clk0);
		@(negedge clk0);
		reset = 1'b0;

		// Read side must stay quiet until the first transfer
		for (int i = 0; i < 4; i++) begin
			@(negedge clk0);
			compare_value("reset_idle", 128'h0, {124'h0, rdy});
			data = prdata0 | {64'h0, prdata1} | {96'h0, prdata2} | {120'h0, prdata3};
			compare_value("reset_idle", 128'h0, data);
		end

		// Known background in every line, so any later read has a reference
		for (int l = 0; l < mpmc_cfg_pkg::DEPTH; l++) begin
			for (int b = 0; b < 16; b++) begin
				data[b*8 +: 8] = fill_byte(12'(l * 16 + b));
			end
			run_xfer(0, "fill", 1'b1, 12'(l * 16), data, 16'hffff);
		end

		// Full-width write and read back on every channel
		for (int ch = 0; ch < 4; ch++) begin
			for (int i = 0; i < 8; i++) begin
				addr = rand_addr(ch, 0, mpmc_cfg_pkg::DEPTH);
				data = {$urandom, $urandom, $urandom, $urandom};
				run_xfer(ch, "full_width", 1'b1, addr, data, 16'hffff);
				run_xfer(ch, "full_width", 1'b0, addr, '0, '0);
			end
		end

		// One line, then each byte through channel 3 and each word through channel 2
		line_no = int'($urandom % mpmc_cfg_pkg::DEPTH);
		data = {$urandom, $urandom, $urandom, $urandom};
		run_xfer(0, "narrow_steer", 1'b1, 12'(line_no * 16), data, 16'hffff);
		for (int b = 0; b < 16; b++) begin
			run_xfer(3, "narrow_steer", 1'b0, 12'(line_no * 16 + b), '0, '0);
		end
		for (int w = 0; w < 4; w++) begin
			run_xfer(2, "narrow_steer", 1'b0, 12'(line_no * 16 + w * 4), '0, '0);
		end

		// Partial strobes on each half, the other bytes of the line must survive
		for (int h = 0; h < 2; h++) begin
			line_no = int'($urandom % mpmc_cfg_pkg::DEPTH);
			data = {$urandom, $urandom, $urandom, $urandom};
			run_xfer(0, "narrow_merge", 1'b1, 12'(line_no * 16), data, 16'hffff);
			data = {$urandom, $urandom, $urandom, $urandom};
			run_xfer(1, "narrow_merge", 1'b1, 12'(line_no * 16 + h * 8), data, 16'h0096);
			run_xfer(0, "narrow_merge", 1'b0, 12'(line_no * 16), '0, '0);
		end

		// All four channels at once, 200 transfers in total
		fork
			mix_traffic(0);
			mix_traffic(1);
			mix_traffic(2);
			mix_traffic(3);
		join

		repeat (4) @(negedge clk0);
		$display("Done with %0d value errors and %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/mpmc_cfg_pkg.sv
verilog/mpmc_line_pkg.sv
verilog/mpmc_apb_port.sv
verilog/mpmc_arbiter.sv
verilog/mpmc_line_ram.sv
verilog/mpmc_data_output.sv
verilog/mpmc_top.sv
verif/mpmc_props.sv
verif/mpmc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mpmc_tb -f sim.f -o mpmc_sim

status=0
./obj_dir/mpmc_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulation stopped with exit status $status"
	exit 1
fi
echo "Simulation finished without failures"
